// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
LINT     := --lint-only --timing -Wall
TOP      := tb_nts_dispatcher
RTL_TOP  := nts_dispatcher
FILELIST := nts_dispatcher.f
OBJ_DIR  := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "Regression passed"

lint:
	$(SIM) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/dispatch_consts.svh ====
//--------------------------------------------------------------------
// Constants for the NTS receive dispatcher
// Buffer geometry, MAC beat widths, register API widths,
// register map, core name and version words
//--------------------------------------------------------------------
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// Frame buffer geometry
`define NTS_ADDR_WIDTH      8        // 256 words per buffer
`define NTS_DATA_WIDTH      64       // MAC beat
`define NTS_VALID_WIDTH     8        // One bit per byte

// Register API bus
`define NTS_API_ADDR_WIDTH  12
`define NTS_API_DATA_WIDTH  32

// Register map
`define NTS_REG_NAME0            12'h000
`define NTS_REG_NAME1            12'h001
`define NTS_REG_VERSION          12'h002
`define NTS_REG_DUMMY            12'h003  // Scratch
`define NTS_REG_FRAMES_MSB       12'h020
`define NTS_REG_FRAMES_LSB       12'h021
`define NTS_REG_GOOD_MSB         12'h022
`define NTS_REG_GOOD_LSB         12'h023
`define NTS_REG_BAD_MSB          12'h024
`define NTS_REG_BAD_LSB          12'h025
`define NTS_REG_DISPATCHED_MSB   12'h026
`define NTS_REG_DISPATCHED_LSB   12'h027

`define NTS_CORE_NAME     64'h4e54_532d_4449_5350  // "NTS-DISP"
`define NTS_CORE_VERSION  32'h302e_3031            // "0.01"

`endif

// ==== common/nts_api_pkg.sv ====
//--------------------------------------------------------------------
// Register API types
// Bus request and receive event flags
//--------------------------------------------------------------------
`default_nettype none
`include "dispatch_consts.svh"

package nts_api_pkg;

  // One API access, sampled with cs
  typedef struct packed {
    logic                           cs;
    logic                           we;     // 1 = write, 0 = read
    logic [`NTS_API_ADDR_WIDTH-1:0] addr;
    logic [`NTS_API_DATA_WIDTH-1:0] wdata;
  } api_req_t;

  // Single cycle pulses feeding the event counters
  typedef struct packed {
    logic sof;         // Start of frame seen
    logic good;        // Frame ended good
    logic bad;         // Frame ended bad
    logic dispatched;  // Engine started a readout
  } rx_events_t;

endpackage

`default_nettype wire

// ==== common/nts_rx_pkg.sv ====
//--------------------------------------------------------------------
// Receive path types
// MAC beat, buffer word index, frame descriptor, buffer states
//--------------------------------------------------------------------
`default_nettype none
`include "dispatch_consts.svh"

package nts_rx_pkg;

  // One beat from the MAC, valid mask on top
  typedef struct packed {
    logic [`NTS_VALID_WIDTH-1:0] valid;  // Byte valid, bit 0 = byte 0
    logic [`NTS_DATA_WIDTH-1:0]  data;
  } rx_beat_t;

  typedef logic [`NTS_ADDR_WIDTH-1:0] buf_addr_t;  // Word index in a buffer

  // What the engine needs to know about a received frame
  typedef struct packed {
    buf_addr_t                   last_idx;  // Index of last word
    logic [`NTS_VALID_WIDTH-1:0] valid;     // Mask of last beat
  } frame_desc_t;

  // Life cycle of one ping-pong buffer
  typedef enum logic [3:0] {
    EMPTY,      // Free
    FILLING,    // MAC writing
    RECEIVED,   // Good frame, waiting for handover
    READY,      // Offered to the engine
    READ_INIT,  // First RAM read in flight
    READING,    // Words streaming out
    READ_DONE   // Held until discard
  } buf_state_e;

endpackage

`default_nettype wire

// ==== design/dispatch_api.sv ====
//--------------------------------------------------------------------
// Register API of the dispatcher
// Register map decode, scratch register, four 64-bit event
// counters with LSB latches for consistent reads
//--------------------------------------------------------------------
`default_nettype none
`include "dispatch_consts.svh"

module dispatch_api (
  input  wire                             i_clk,
  input  wire                             i_areset,
  input  wire nts_api_pkg::api_req_t      i_req,
  input  wire nts_api_pkg::rx_events_t    i_events,
  output logic [`NTS_API_DATA_WIDTH-1:0]  o_rdata   // Combinational
);

  localparam int          NUM_CNT      = 4;  // Frames, good, bad, dispatched
  localparam logic [63:0] CORE_NAME    = `NTS_CORE_NAME;
  localparam logic [31:0] CORE_VERSION = `NTS_CORE_VERSION;

  logic [`NTS_API_DATA_WIDTH-1:0] dummy_reg;
  logic [63:0]                    cnt_reg [NUM_CNT];
  logic [31:0]                    lsb_reg [NUM_CNT];  // Latched low halves
  logic [NUM_CNT-1:0]             cnt_inc;
  logic [NUM_CNT-1:0]             lsb_we;
  logic                           rd_en;
  logic                           dummy_we;

  assign cnt_inc  = {i_events.dispatched, i_events.bad, i_events.good, i_events.sof};
  assign rd_en    = i_req.cs && !i_req.we;
  assign dummy_we = i_req.cs && i_req.we && (i_req.addr == `NTS_REG_DUMMY);

  //------------------------------------------------------------------
  // Read decode
  //------------------------------------------------------------------
  // MSB read also arms the LSB latch of that counter
  always_comb begin
    o_rdata = '0;   // Unmapped
    lsb_we  = '0;
    if (rd_en) begin
      case (i_req.addr)
        `NTS_REG_NAME0:          o_rdata = CORE_NAME[63:32];
        `NTS_REG_NAME1:          o_rdata = CORE_NAME[31:0];
        `NTS_REG_VERSION:        o_rdata = CORE_VERSION;
        `NTS_REG_DUMMY:          o_rdata = dummy_reg;
        `NTS_REG_FRAMES_MSB: begin
          o_rdata   = cnt_reg[0][63:32];
          lsb_we[0] = 1'b1;
        end
        `NTS_REG_FRAMES_LSB:     o_rdata = lsb_reg[0];
        `NTS_REG_GOOD_MSB: begin
          o_rdata   = cnt_reg[1][63:32];
          lsb_we[1] = 1'b1;
        end
        `NTS_REG_GOOD_LSB:       o_rdata = lsb_reg[1];
        `NTS_REG_BAD_MSB: begin
          o_rdata   = cnt_reg[2][63:32];
          lsb_we[2] = 1'b1;
        end
        `NTS_REG_BAD_LSB:        o_rdata = lsb_reg[2];
        `NTS_REG_DISPATCHED_MSB: begin
          o_rdata   = cnt_reg[3][63:32];
          lsb_we[3] = 1'b1;
        end
        `NTS_REG_DISPATCHED_LSB: o_rdata = lsb_reg[3];
        default: ;
      endcase
    end
  end

  //------------------------------------------------------------------
  // Scratch, counters and latches
  //------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      dummy_reg <= '0;
      for (int k = 0; k < NUM_CNT; k++) begin
        cnt_reg[k] <= '0;
        lsb_reg[k] <= '0;
      end
    end else begin
      if (dummy_we) dummy_reg <= i_req.wdata;
      for (int k = 0; k < NUM_CNT; k++) begin
        if (cnt_inc[k]) cnt_reg[k] <= cnt_reg[k] + 64'd1;
        if (lsb_we[k])  lsb_reg[k] <= cnt_reg[k][31:0];   // Value before this edge
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/nts_dispatcher.sv ====
//--------------------------------------------------------------------
// NTS receive dispatcher top level
// MAC front end, ping-pong buffer controller, register API
//--------------------------------------------------------------------
`default_nettype none
`include "dispatch_consts.svh"

module nts_dispatcher (
  input  wire                            i_clk,
  input  wire                            i_areset,
  input  wire nts_rx_pkg::rx_beat_t      i_rx_beat,
  input  wire                            i_rx_good,
  input  wire                            i_rx_bad,
  output logic                           o_packet_available,
  output nts_rx_pkg::frame_desc_t        o_frame_desc,
  output logic                           o_fifo_empty,
  input  wire                            i_rd_start,
  input  wire                            i_discard,
  output logic                           o_fifo_rd_valid,
  output logic [`NTS_DATA_WIDTH-1:0]     o_fifo_rd_data,
  input  wire nts_api_pkg::api_req_t     i_api_req,
  output logic [`NTS_API_DATA_WIDTH-1:0] o_api_rdata
);

  import nts_rx_pkg::*;
  import nts_api_pkg::*;

  rx_beat_t   front_beat;   // Left-aligned beat
  logic       front_sof;
  rx_events_t events;

  // Counter events, all single cycle
  assign events = '{sof: front_sof, good: i_rx_good, bad: i_rx_bad, dispatched: i_rd_start};

  rx_frame_front u_front (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_beat   (i_rx_beat),
    .o_beat   (front_beat),
    .o_sof    (front_sof)
  );

  frame_buffer_ctrl u_buf_ctrl (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_beat             (front_beat),
    .i_sof              (front_sof),
    .i_rx_good          (i_rx_good),
    .i_rx_bad           (i_rx_bad),
    .i_rd_start         (i_rd_start),
    .i_discard          (i_discard),
    .o_packet_available (o_packet_available),
    .o_frame_desc       (o_frame_desc),
    .o_fifo_empty       (o_fifo_empty),
    .o_fifo_rd_valid    (o_fifo_rd_valid),
    .o_fifo_rd_data     (o_fifo_rd_data)
  );

  dispatch_api u_api (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_req    (i_api_req),
    .i_events (events),
    .o_rdata  (o_api_rdata)
  );

endmodule

`default_nettype wire

// ==== design/rx_frame_front.sv ====
//--------------------------------------------------------------------
// MAC receive front end
// Start of frame detector and last word byte aligner
//--------------------------------------------------------------------
`default_nettype none
`include "dispatch_consts.svh"

module rx_frame_front (
  input  wire                       i_clk,
  input  wire                       i_areset,
  input  wire nts_rx_pkg::rx_beat_t i_beat,
  output nts_rx_pkg::rx_beat_t      o_beat,   // Same cycle, aligned
  output logic                      o_sof
);

  logic [`NTS_VALID_WIDTH-1:0] prev_valid;   // Mask of the previous beat
  logic [`NTS_DATA_WIDTH-1:0]  aligned;

  // Nonzero after reset so the first beat never looks like a start
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      prev_valid <= '1;
    end else begin
      prev_valid <= i_beat.valid;
    end
  end

  // Idle to full beat
  assign o_sof = (prev_valid == '0) && (i_beat.valid == '1);

  //------------------------------------------------------------------
  // Byte aligner
  //------------------------------------------------------------------
  // Mask 0xFF >> k has its valid bytes low, shift them k bytes up
  always_comb begin
    aligned = '0;  // Odd or empty mask
    for (int k = 0; k < `NTS_VALID_WIDTH; k++) begin
      if (i_beat.valid == ({`NTS_VALID_WIDTH{1'b1}} >> k)) begin
        aligned = i_beat.data << (8 * k);
      end
    end
  end

  assign o_beat = '{valid: i_beat.valid, data: aligned};

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
//--------------------------------------------------------------------
// Testbench clock and reset generator
// Free running clock, reset held for a few cycles
//--------------------------------------------------------------------
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_areset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_areset <= 1'b0;  // Released on an edge, flops still see reset there
  end

endmodule

`default_nettype wire

// ==== dv/tb_nts_dispatcher.sv ====
//--------------------------------------------------------------------
// Testbench for the NTS receive dispatcher
// Random MAC frames from an LCG, queue of expected words and
// descriptors, engine readout and discard, counter and register
// checks over the API, watchdog
//--------------------------------------------------------------------
`default_nettype none
`include "dispatch_consts.svh"

module tb_nts_dispatcher;
  timeunit 1ns;
  timeprecision 100ps;

  import nts_rx_pkg::*;
  import nts_api_pkg::*;

  localparam int N_RAND          = 24;  // Single frames of random outcome
  localparam int N_PAIRS         = 4;   // Back to back good pairs
  localparam int NUM_FRAMES      = N_RAND + 2 * N_PAIRS;
  localparam int WATCHDOG_CYCLES = 2000 + 60 * NUM_FRAMES;
  localparam logic [31:0] EXP_NAME0   = "NTS-";
  localparam logic [31:0] EXP_NAME1   = "DISP";
  localparam logic [31:0] EXP_VERSION = "0.01";

  logic                           clk;
  logic                           areset;
  rx_beat_t                       rx_beat;
  logic                           rx_good;
  logic                           rx_bad;
  logic                           packet_available;
  frame_desc_t                    frame_desc;
  logic                           fifo_empty;
  logic                           rd_start;
  logic                           discard;
  logic                           fifo_rd_valid;
  logic [`NTS_DATA_WIDTH-1:0]     fifo_rd_data;
  api_req_t                       api_req;
  logic [`NTS_API_DATA_WIDTH-1:0] api_rdata;

  // Reference model
  frame_desc_t                exp_desc_q [$];
  logic [`NTS_DATA_WIDTH-1:0] exp_word_q [$];  // Aligned words of all frames
  logic [63:0] cnt_sof, cnt_good, cnt_bad, cnt_disp;
  logic [31:0] rng_state;
  int err_data, err_desc, err_api, err_flag, err_proto;

  tb_clock_gen u_clk_gen (.o_clk(clk), .o_areset(areset));

  nts_dispatcher i_dut (
    .i_clk (clk), .i_areset (areset),
    .i_rx_beat (rx_beat), .i_rx_good (rx_good), .i_rx_bad (rx_bad),
    .o_packet_available (packet_available), .o_frame_desc (frame_desc),
    .o_fifo_empty (fifo_empty), .i_rd_start (rd_start), .i_discard (discard),
    .o_fifo_rd_valid (fifo_rd_valid), .o_fifo_rd_data (fifo_rd_data),
    .i_api_req (api_req), .o_api_rdata (api_rdata)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Valid bytes sit low in the beat and land at the top of the word
  function automatic logic [`NTS_DATA_WIDTH-1:0] aligned_word(
      input logic [`NTS_DATA_WIDTH-1:0] data, input logic [`NTS_VALID_WIDTH-1:0] mask);
    logic [`NTS_DATA_WIDTH-1:0] word;
    int                         n_valid;
    word    = '0;
    n_valid = $countones(mask);
    for (int b = 0; b < n_valid; b++) begin
      word[8 * (`NTS_VALID_WIDTH - n_valid + b) +: 8] = data[8 * b +: 8];
    end
    return word;
  endfunction

  //------------------------------------------------------------------
  // Compare tasks
  //------------------------------------------------------------------
  task automatic check_word(input string name, input logic [`NTS_DATA_WIDTH-1:0] exp,
                            input logic [`NTS_DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
      err_data++;
    end
  endtask

  task automatic check_desc(input frame_desc_t exp, input frame_desc_t act);
    if (act !== exp) begin
      $display("ERROR o_frame_desc expected 0x%h actual 0x%h at %0t", exp, act, $time);
      err_desc++;
    end
  endtask

  task automatic check_api(input string name, input logic [`NTS_API_DATA_WIDTH-1:0] exp,
                           input logic [`NTS_API_DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
      err_api++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
      err_flag++;
    end
  endtask

  task automatic protocol_error(input string msg);
    $display("%s (at %0t)", msg, $time);
    err_proto++;
  endtask

  //------------------------------------------------------------------
  // MAC side
  //------------------------------------------------------------------
  task automatic draw_frame(output int len, output int shift, output bit good);
    len   = 1 + int'((next_rand() >> 16) % 20);
    shift = (len == 1) ? 0 : int'((next_rand() >> 16) % 8);  // Single beat stays full
    good  = ((next_rand() >> 16) % 4) != 0;                   // One in four bad
  endtask

  // Beats on consecutive edges and then one idle beat
  task automatic send_frame(input int len, input int shift, input bit good);
    logic [`NTS_DATA_WIDTH-1:0]  data;
    logic [`NTS_VALID_WIDTH-1:0] mask;
    frame_desc_t                 desc;
    for (int b = 0; b < len; b++) begin
      data = {next_rand(), next_rand()};
      mask = (b == len - 1) ? (8'hFF >> shift) : 8'hFF;
      @(posedge clk);
      rx_beat <= '{valid: mask, data: data};
      rx_good <= (b == len - 1) && good;
      rx_bad  <= (b == len - 1) && !good;
      if (good) exp_word_q.push_back(aligned_word(data, mask));
    end
    @(posedge clk);
    rx_beat <= '0;
    rx_good <= 1'b0;
    rx_bad  <= 1'b0;
    cnt_sof++;
    if (good) begin
      cnt_good++;
      desc.last_idx = buf_addr_t'(len - 1);
      desc.valid    = mask;  // Mask of the last beat
      exp_desc_q.push_back(desc);
    end else begin
      cnt_bad++;
    end
  endtask

  //------------------------------------------------------------------
  // Engine side
  //------------------------------------------------------------------
  task automatic read_frame();
    frame_desc_t                exp_desc;
    logic [`NTS_DATA_WIDTH-1:0] exp_word;
    int                         cycles;
    bit                         dropped;
    exp_desc = exp_desc_q.pop_front();
    cycles   = 0;
    dropped  = 1'b0;
    @(negedge clk);
    while (!packet_available && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (!packet_available) begin
      protocol_error("Good frame never became available to the engine");
      for (int i = 0; i <= int'(exp_desc.last_idx); i++) begin
        exp_word = exp_word_q.pop_front();
      end
      return;
    end
    check_desc(exp_desc, frame_desc);
    check_flag("o_fifo_empty", 1'b0, fifo_empty);  // Low from handover on
    @(posedge clk);
    rd_start <= 1'b1;
    cnt_disp++;
    @(posedge clk);                 // Sampled here
    rd_start <= 1'b0;
    cycles = 1;
    @(negedge clk);
    while (!fifo_rd_valid && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles != 3) protocol_error($sformatf("Readout began %0d cycles after start, not 3",
                                              cycles));
    for (int i = 0; i <= int'(exp_desc.last_idx); i++) begin
      exp_word = exp_word_q.pop_front();
      if (fifo_rd_valid) begin
        check_word("o_fifo_rd_data", exp_word, fifo_rd_data);
        check_flag("o_fifo_empty", 1'b0, fifo_empty);
      end else if (!dropped) begin
        protocol_error("o_fifo_rd_valid fell before the last word");
        dropped = 1'b1;
      end
      @(negedge clk);
    end
    if (fifo_rd_valid) protocol_error("o_fifo_rd_valid stayed high past the last word");
  endtask

  task automatic discard_frame();
    int delay;
    delay = int'((next_rand() >> 16) % 8);
    repeat (delay) @(posedge clk);
    @(posedge clk);
    discard <= 1'b1;
    @(posedge clk);
    discard <= 1'b0;
    @(negedge clk);
    check_flag("o_fifo_empty", 1'b1, fifo_empty);
  endtask

  // Bad frame must not reach the engine
  task automatic check_no_frame();
    repeat (6) begin
      @(negedge clk);
      check_flag("o_packet_available", 1'b0, packet_available);
    end
  endtask

  //------------------------------------------------------------------
  // Register API
  //------------------------------------------------------------------
  // Read data settles by the falling edge after the request
  task automatic api_access(input logic we, input logic [`NTS_API_ADDR_WIDTH-1:0] addr,
                            input logic [`NTS_API_DATA_WIDTH-1:0] wdata);
    @(posedge clk);
    api_req <= '{cs: 1'b1, we: we, addr: addr, wdata: wdata};
    @(negedge clk);
  endtask

  task automatic check_counter(input string name, input logic [11:0] msb_addr,
                               input logic [11:0] lsb_addr, input logic [63:0] exp);
    api_access(1'b0, msb_addr, '0);  // Latches the low half
    check_api({"o_api_rdata ", name, " msb"}, exp[63:32], api_rdata);
    api_access(1'b0, lsb_addr, '0);
    check_api({"o_api_rdata ", name, " lsb"}, exp[31:0], api_rdata);
  endtask

  function automatic int error_total();
    return err_data + err_desc + err_api + err_flag + err_proto;
  endfunction

  task automatic report_counts();
    $display("Error counts: data %0d, desc %0d, api %0d, flag %0d, protocol %0d",
             err_data, err_desc, err_api, err_flag, err_proto);
  endtask

  //------------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------------
  initial begin : main
    logic [31:0] scratch;
    int          len;
    int          shift;
    bit          good;
    rng_state = 32'd21266;
    {cnt_sof, cnt_good, cnt_bad, cnt_disp} = '0;
    {err_data, err_desc, err_api, err_flag, err_proto} = '0;
    rx_beat  = '0;
    rx_good  = 1'b0;
    rx_bad   = 1'b0;
    rd_start = 1'b0;
    discard  = 1'b0;
    api_req  = '0;
    @(negedge areset);
    @(negedge clk);
    check_flag("o_packet_available", 1'b0, packet_available);
    check_flag("o_fifo_empty", 1'b1, fifo_empty);
    check_flag("o_fifo_rd_valid", 1'b0, fifo_rd_valid);
    check_word("o_fifo_rd_data", '0, fifo_rd_data);

    // Good frames are read out and discarded one at a time
    for (int f = 0; f < N_RAND; f++) begin
      draw_frame(len, shift, good);
      if (f == 1) good = 1'b0;   // At least one bad frame
      send_frame(len, shift, good);
      if (good) begin
        read_frame();
        discard_frame();
      end else begin
        check_no_frame();
      end
    end

    // Second frame waits in its buffer until the first is discarded
    for (int p = 0; p < N_PAIRS; p++) begin
      draw_frame(len, shift, good);
      send_frame(len, shift, 1'b1);
      draw_frame(len, shift, good);
      send_frame(len, shift, 1'b1);
      read_frame();
      check_flag("o_packet_available", 1'b0, packet_available);
      discard_frame();
      read_frame();
      discard_frame();
    end

    check_counter("frames", `NTS_REG_FRAMES_MSB, `NTS_REG_FRAMES_LSB, cnt_sof);
    check_counter("good", `NTS_REG_GOOD_MSB, `NTS_REG_GOOD_LSB, cnt_good);
    check_counter("bad", `NTS_REG_BAD_MSB, `NTS_REG_BAD_LSB, cnt_bad);
    check_counter("dispatched", `NTS_REG_DISPATCHED_MSB, `NTS_REG_DISPATCHED_LSB, cnt_disp);

    api_access(1'b0, `NTS_REG_NAME0, '0);
    check_api("o_api_rdata name0", EXP_NAME0, api_rdata);
    api_access(1'b0, `NTS_REG_NAME1, '0);
    check_api("o_api_rdata name1", EXP_NAME1, api_rdata);
    api_access(1'b0, `NTS_REG_VERSION, '0);
    check_api("o_api_rdata version", EXP_VERSION, api_rdata);
    repeat (2) begin
      scratch = next_rand();
      api_access(1'b1, `NTS_REG_DUMMY, scratch);
      api_access(1'b0, `NTS_REG_DUMMY, '0);
      check_api("o_api_rdata dummy", scratch, api_rdata);
    end
    @(posedge clk);
    api_req <= '0;

    report_counts();
    if (error_total() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Budget scales with the number of frames
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired, run did not finish within %0d cycles", WATCHDOG_CYCLES);
    report_counts();
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== frame_buffer/frame_buffer_ctrl.sv ====
//--------------------------------------------------------------------
// Ping-pong frame buffer controller
// Two buffer state machines, MAC write path, engine readout
// sequencer and the two frame RAMs
//--------------------------------------------------------------------
`default_nettype none
`include "dispatch_consts.svh"

module frame_buffer_ctrl (
  input  wire                        i_clk,
  input  wire                        i_areset,
  input  wire nts_rx_pkg::rx_beat_t  i_beat,        // Aligned beat
  input  wire                        i_sof,
  input  wire                        i_rx_good,
  input  wire                        i_rx_bad,
  input  wire                        i_rd_start,
  input  wire                        i_discard,
  output logic                       o_packet_available,
  output nts_rx_pkg::frame_desc_t    o_frame_desc,
  output logic                       o_fifo_empty,
  output logic                       o_fifo_rd_valid,
  output logic [`NTS_DATA_WIDTH-1:0] o_fifo_rd_data
);

  import nts_rx_pkg::*;

  logic                       rx_sel;      // Buffer owned by the MAC
  logic                       rd_sel;      // Buffer handed to the engine
  buf_state_e                 state [2];
  frame_desc_t                desc  [2];
  logic [1:0]                 wr_en;       // One write per accepted beat
  buf_addr_t                  wr_addr;
  logic [`NTS_DATA_WIDTH-1:0] wr_data;
  logic [`NTS_DATA_WIDTH-1:0] rd_data [2];
  buf_addr_t                  rd_addr;
  buf_addr_t                  out_cnt;     // Words already sent
  logic                       beat_valid;

  assign rd_sel     = ~rx_sel;
  assign beat_valid = |i_beat.valid;

  assign o_packet_available = (state[rd_sel] == READY);
  assign o_frame_desc       = desc[rd_sel];
  // Not empty from handover until the last word is off the bus
  assign o_fifo_empty = !((state[rd_sel] inside {READY, READ_INIT, READING}) ||
                          o_fifo_rd_valid);

  //------------------------------------------------------------------
  // Frame RAMs
  //------------------------------------------------------------------
  for (genvar i = 0; i < 2; i++) begin : g_ram
    frame_buffer_ram u_ram (
      .i_clk   (i_clk),
      .i_addr  (wr_en[i] ? wr_addr : rd_addr),  // Write wins
      .i_write (wr_en[i]),
      .i_wdata (wr_data),
      .o_rdata (rd_data[i])
    );
  end

  // Write data and address, one cycle behind the beat
  always_ff @(posedge i_clk) begin
    wr_data <= i_beat.data;
    wr_addr <= (state[rx_sel] == EMPTY) ? '0 : desc[rx_sel].last_idx + 1'b1;
  end

  //------------------------------------------------------------------
  // Buffer state machines
  //------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      rx_sel          <= 1'b0;
      state           <= '{EMPTY, EMPTY};
      desc            <= '{default: '0};
      wr_en           <= '0;
      rd_addr         <= '0;
      out_cnt         <= '0;
      o_fifo_rd_valid <= 1'b0;
      o_fifo_rd_data  <= '0;
    end else begin
      wr_en <= '0;

      // Receive side
      if (i_rx_bad && (state[rx_sel] inside {EMPTY, FILLING})) begin
        state[rx_sel] <= EMPTY;  // Throw the frame away
        desc[rx_sel]  <= '0;
      end else begin
        case (state[rx_sel])
          EMPTY: begin
            if (beat_valid) begin
              wr_en[rx_sel]          <= 1'b1;  // Word 0
              desc[rx_sel].last_idx <= '0;
            end
            if (i_sof && i_rx_good) begin      // Single beat frame
              desc[rx_sel].valid <= i_beat.valid;
              state[rx_sel]      <= RECEIVED;
            end else if (i_sof) begin
              state[rx_sel] <= FILLING;
            end
          end
          FILLING: begin
            // Beats past the last word are dropped
            if (beat_valid && (desc[rx_sel].last_idx != '1)) begin
              wr_en[rx_sel]          <= 1'b1;
              desc[rx_sel].last_idx <= desc[rx_sel].last_idx + 1'b1;
            end
            if (i_rx_good) begin
              desc[rx_sel].valid <= i_beat.valid;
              state[rx_sel]      <= RECEIVED;
            end
          end
          RECEIVED: begin
            // Hand over once the engine side is free
            if (state[rd_sel] == EMPTY) begin
              state[rx_sel] <= READY;
              rx_sel        <= rd_sel;
            end
          end
          default: ;
        endcase
      end

      // Read side
      if (i_discard) begin
        state[rd_sel]   <= EMPTY;
        o_fifo_rd_valid <= 1'b0;
      end else begin
        case (state[rd_sel])
          READY: begin
            rd_addr <= '0;
            out_cnt <= '0;
            if (i_rd_start) state[rd_sel] <= READ_INIT;
          end
          READ_INIT: begin                   // Word 0 address on the RAM
            rd_addr       <= rd_addr + 1'b1;
            state[rd_sel] <= READING;
          end
          READING: begin
            rd_addr         <= rd_addr + 1'b1;  // Runs one ahead of output
            out_cnt         <= out_cnt + 1'b1;
            o_fifo_rd_valid <= 1'b1;
            o_fifo_rd_data  <= rd_data[rd_sel];
            if (out_cnt == desc[rd_sel].last_idx) state[rd_sel] <= READ_DONE;
          end
          READ_DONE: o_fifo_rd_valid <= 1'b0;   // Wait for discard
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== frame_buffer/frame_buffer_ram.sv ====
//--------------------------------------------------------------------
// Single port frame RAM
// One frame of 64-bit words, registered read
//--------------------------------------------------------------------
`default_nettype none
`include "dispatch_consts.svh"

module frame_buffer_ram (
  input  wire                       i_clk,
  input  wire [`NTS_ADDR_WIDTH-1:0] i_addr,   // Write or read address
  input  wire                       i_write,
  input  wire [`NTS_DATA_WIDTH-1:0] i_wdata,
  output logic [`NTS_DATA_WIDTH-1:0] o_rdata
);

  localparam int DEPTH = 2 ** `NTS_ADDR_WIDTH;

  logic [`NTS_DATA_WIDTH-1:0] mem [DEPTH];

  // Read returns old contents on a write cycle
  always_ff @(posedge i_clk) begin
    if (i_write) mem[i_addr] <= i_wdata;
    o_rdata <= mem[i_addr];
  end

endmodule

`default_nettype wire

// ==== nts_dispatcher.f ====
+incdir+common
common/nts_rx_pkg.sv
common/nts_api_pkg.sv
frame_buffer/frame_buffer_ram.sv
frame_buffer/frame_buffer_ctrl.sv
design/rx_frame_front.sv
design/dispatch_api.sv
design/nts_dispatcher.sv
dv/tb_clock_gen.sv
dv/tb_nts_dispatcher.sv
